//--- testbench/alu_stimulus.txt
# op a b expected_result expected_cmp, all fields in hex
# op is the numeric alu_op_e code from alu_pkg
00 7fffffffffffffff 0000000000000001 8000000000000000 0
00 ffffffffffffffff 0000000000000002 0000000000000001 0
01 0000000000000000 0000000000000001 ffffffffffffffff 0
01 123456789abcdef0 0fedcba987654321 02468acf13579bcf 0
02 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 f000f000f000f000 0
03 f0f0f0f0f0f0f0f0 0f0f0f0f00000000 fffffffff0f0f0f0 0
04 aaaaaaaaaaaaaaaa ffffffff00000000 55555555aaaaaaaa 0
05 0000000000000001 000000000000003f 8000000000000000 0
05 123456789abcdef0 0000000000000000 123456789abcdef0 0
06 8000000000000000 000000000000003f 0000000000000001 0
06 ffffffffffffffff 0000000000000020 00000000ffffffff 0
07 8000000000000000 000000000000003f ffffffffffffffff 0
07 f000000000000000 0000000000000020 fffffffff0000000 0
08 0000000000000001 000000000000001f ffffffff80000000 0
08 ffffffff00000001 0000000000000020 0000000000000001 0
09 0000000080000000 000000000000001f 0000000000000001 0
09 0000000080000000 0000000000000000 ffffffff80000000 0
0a 0000000080000000 000000000000001f ffffffffffffffff 0
0a ffffffff7ffffff0 0000000000000004 0000000007ffffff 0
0b 8000000000000001 0000000000000001 0000000000000001 1
0c 8000000000000001 0000000000000001 0000000000000000 0
0d 0000000000000005 0000000000000005 0000000000000001 1
0d 8000000000000001 0000000000000001 0000000000000000 0
0e 8000000000000001 0000000000000001 0000000000000001 1
0f 0000000000000001 8000000000000001 0000000000000000 0
10 0000000000000001 8000000000000001 0000000000000001 1
11 0000000000000001 8000000000000001 0000000000000001 1
12 8000000000000001 0000000000000001 0000000000000001 1
12 0000000000000001 8000000000000001 0000000000000000 0
13 ffffffffffffffff 0000000000000007 fffffffffffffff9 0
13 00000000ffffffff 00000000ffffffff fffffffe00000001 0
14 ffffffffffffffff 0000000000000007 ffffffffffffffff 0
14 8000000000000000 8000000000000000 4000000000000000 0
15 ffffffffffffffff ffffffffffffffff ffffffffffffffff 0
15 0000000000000002 ffffffffffffffff 0000000000000001 0
16 ffffffffffffffff ffffffffffffffff fffffffffffffffe 0
17 0000000000010000 0000000000008000 ffffffff80000000 0
17 ffffffff00000003 0000000500000002 0000000000000006 0
18 fffffffffffffff9 0000000000000002 fffffffffffffffd 0
18 8000000000000000 ffffffffffffffff 8000000000000000 0
18 0000000000000007 0000000000000000 ffffffffffffffff 0
19 ffffffffffffffff 0000000000000002 7fffffffffffffff 0
19 0000000000000005 0000000000000000 ffffffffffffffff 0
1a fffffffffffffff9 0000000000000002 ffffffffffffffff 0
1a 8000000000000000 ffffffffffffffff 0000000000000000 0
1a fffffffffffffff9 0000000000000000 fffffffffffffff9 0
1b ffffffffffffffff 0000000000000010 000000000000000f 0
1b 0000000000001234 0000000000000000 0000000000001234 0
1c 0000000080000000 00000000ffffffff ffffffff80000000 0
1c ffffffff00000064 fffffffffffffff6 fffffffffffffff6 0
1d ffffffffffffffff 0000000000000002 000000007fffffff 0
1d 0000000012345678 ffffffff00000000 ffffffffffffffff 0
1e 00000000fffffff9 0000000000000003 ffffffffffffffff 0
1e 0000000080000000 00000000ffffffff 0000000000000000 0
1f 00000000fffffff9 0000000000000000 fffffffffffffff9 0
1f 0000000080000007 0000000000000010 0000000000000007 0

//--- flist.f
hw/alu_pkg.sv
hw/alu_addsub_cmp.sv
hw/alu_shift.sv
hw/alu_mul.sv
hw/alu_div.sv
hw/alu_top.sv
testbench/alu_assertions.sv
testbench/tb_alu_top.sv

//--- Bender.yml
package:
  name: alu_exec

sources:
  # design
  - hw/alu_pkg.sv
  - hw/alu_addsub_cmp.sv
  - hw/alu_shift.sv
  - hw/alu_mul.sv
  - hw/alu_div.sv
  - hw/alu_top.sv

  # testbench
  - target: test
    files:
      - testbench/alu_assertions.sv
      - testbench/tb_alu_top.sv

//--- testbench/tb_alu_top.sv
`default_nettype none

module tb_alu_top;

  import alu_pkg::*;

  localparam int CLK_HALF     = 20;
  localparam int DRV_DELAY    = 2;   // input skew after the rising edge
  localparam int RESET_CYCLES = 10;
  localparam int STALL_MARGIN = 32;  // room for random back-pressure

  logic     clk;
  logic     rst_n_i;
  logic     req_valid_i;
  logic     req_ready_o;
  alu_req_t req_i;
  logic     rsp_valid_o;
  logic     rsp_ready_i;
  alu_rsp_t rsp_o;

  // vectors from the stimulus file
  alu_req_t        vec_req[$];
  logic [XLEN-1:0] vec_res[$];
  logic            vec_cmp[$];

  logic [31:0] lcg_state;
  int          cycle_cnt;
  int          cycle_limit;  // zero until the vectors are known
  int          rsp_cnt;
  int          errors;

  alu_top alu_top_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o)
  );

  bind alu_top alu_assertions u_alu_assertions (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o)
  );

  always #CLK_HALF clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic end_in_failure();
    $display("TB FAILED");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic check_value(input string name, input logic [XLEN-1:0] actual,
                             input logic [XLEN-1:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected);
      end_in_failure();
    end
  endtask

  task automatic read_vectors();
    int                  fd;
    logic [8*256-1:0]    line;
    logic [ALU_OP_W-1:0] op;
    logic [XLEN-1:0]     a;
    logic [XLEN-1:0]     b;
    logic [XLEN-1:0]     res;
    logic                cmp;
    alu_req_t            r;
    fd = $fopen("testbench/alu_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file testbench/alu_stimulus.txt");
      end_in_failure();
    end else begin
      line = '0;
      while ($fgets(line, fd) != 0) begin
        // comment lines do not scan as five fields
        if ($sscanf(line, "%h %h %h %h %h", op, a, b, res, cmp) == 5) begin
          r.op = alu_op_e'(op);
          r.a  = a;
          r.b  = b;
          vec_req.push_back(r);
          vec_res.push_back(res);
          vec_cmp.push_back(cmp);
        end
        line = '0;
      end
      $fclose(fd);
      if (vec_req.size() == 0) begin
        $display("the stimulus file holds no vectors");
        end_in_failure();
      end
    end
  endtask

  // called just after a rising edge and returns just after the transfer edge
  task automatic send_request(input alu_req_t r);
    req_i       = r;
    req_valid_i = 1'b1;
    @(negedge clk);
    while (!req_ready_o) @(negedge clk);
    @(posedge clk);
    #DRV_DELAY;
    req_valid_i = 1'b0;
  endtask

  task automatic wait_response(output alu_rsp_t rsp);
    @(negedge clk);
    while (!(rsp_valid_o && rsp_ready_i)) @(negedge clk);
    rsp = rsp_o;  // transfers on the next edge
    @(posedge clk);
    #DRV_DELAY;
  endtask

  // random back-pressure with ready about three cycles in four
  always @(posedge clk) begin
    #DRV_DELAY;
    lcg_state   = lcg_next(lcg_state);
    rsp_ready_i = (lcg_state[17:16] != 2'b00);
  end

  always @(negedge clk) begin
    if (rst_n_i && rsp_valid_o && rsp_ready_i) begin
      rsp_cnt++;
    end
  end

  // a failed handshake assertion ends the run too
  always @(negedge clk) begin
    if (alu_top_i.u_alu_assertions.fail_cnt != 0) begin
      $display("a handshake assertion on the DUT ports failed");
      end_in_failure();
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
      end_in_failure();
    end
  end

  initial begin
    alu_rsp_t rsp;
    clk         = 1'b0;
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b0;
    lcg_state   = 32'd32447;
    cycle_cnt   = 0;
    cycle_limit = 0;
    rsp_cnt     = 0;
    errors      = 0;

    read_vectors();
    cycle_limit = RESET_CYCLES + vec_req.size() * (DIV_CYCLES + STALL_MARGIN + 10);

    repeat (RESET_CYCLES) @(posedge clk);
    #DRV_DELAY;
    rst_n_i = 1'b1;
    check_value("req_ready_o after reset", req_ready_o, 1);
    check_value("rsp_valid_o after reset", rsp_valid_o, 0);

    foreach (vec_req[i]) begin
      send_request(vec_req[i]);
      wait_response(rsp);
      check_value($sformatf("rsp_o.result (vector %0d, op %0d)", i, vec_req[i].op),
                  rsp.result, vec_res[i]);
      check_value($sformatf("rsp_o.cmp (vector %0d, op %0d)", i, vec_req[i].op),
                  rsp.cmp, vec_cmp[i]);
      // exactly one transfer per request
      check_value("response count", rsp_cnt, i + 1);
      check_value("rsp_valid_o after transfer", rsp_valid_o, 0);
    end

    if (errors == 0 && alu_top_i.u_alu_assertions.fail_cnt == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      end_in_failure();
    end
  end

endmodule

`default_nettype wire

//--- testbench/alu_assertions.sv
`default_nettype none

module alu_assertions (
  input wire                    clk,
  input wire                    rst_n_i,
  input wire                    req_valid_i,
  input wire                    req_ready_o,
  input wire                    rsp_valid_o,
  input wire                    rsp_ready_i,
  input wire alu_pkg::alu_rsp_t rsp_o
);

  int unsigned fail_cnt = 0;  // assertion failures so far
  logic        pending_q;     // request accepted, response not yet taken

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pending_q <= 1'b0;
    end else if (req_valid_i && req_ready_o) begin
      pending_q <= 1'b1;
    end else if (rsp_valid_o && rsp_ready_i) begin
      pending_q <= 1'b0;
    end
  end

  // stalled response stays valid and unchanged
  property rsp_held_p;
    @(posedge clk) disable iff (!rst_n_i)
      (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o));
  endproperty

  // nothing new accepted until the pending response has transferred
  property no_accept_while_pending_p;
    @(posedge clk) disable iff (!rst_n_i)
      pending_q |-> !req_ready_o;
  endproperty

  property rsp_idle_after_reset_p;
    @(posedge clk) !rst_n_i |=> !rsp_valid_o;
  endproperty

  rsp_held_a: assert property (rsp_held_p)
    else begin
      fail_cnt++;
      $error("response dropped or changed while stalled");
    end

  no_accept_while_pending_a: assert property (no_accept_while_pending_p)
    else begin
      fail_cnt++;
      $error("request port ready while a response is pending");
    end

  rsp_idle_after_reset_a: assert property (rsp_idle_after_reset_p)
    else begin
      fail_cnt++;
      $error("response valid right after reset");
    end

endmodule

`default_nettype wire

//--- hw/alu_top.sv
`default_nettype none

module alu_top (
  input  wire                    clk,
  input  wire                    rst_n_i,
  input  wire                    req_valid_i,
  output logic                   req_ready_o,
  input  wire alu_pkg::alu_req_t req_i,
  output logic                   rsp_valid_o,
  input  wire                    rsp_ready_i,
  output alu_pkg::alu_rsp_t      rsp_o
);

  import alu_pkg::*;

  alu_req_t          req_q;
  logic              act_q;  // request just registered, not yet dispatched
  logic              accept;

  // decoded controls
  logic              is_sub;
  logic              is_cmp;
  logic              is_mul;
  logic              is_div;
  logic [1:0]        sh_kind;
  logic              sh_word;
  logic              mul_a_signed;
  logic              mul_b_signed;
  logic              div_signed;
  logic              div_word;

  logic [XLEN-1:0]   sum;
  logic              lt;
  logic              ltu;
  logic              eq;
  logic [XLEN-1:0]   shift_res;
  logic              cmp_bit;
  logic [XLEN-1:0]   fast_result;
  logic [XLEN-1:0]   slow_result;

  logic              mul_start;
  logic              mul_busy;
  logic              mul_done;
  logic [2*XLEN-1:0] prod;
  logic              div_start;
  logic              div_busy;
  logic              div_done;
  logic [XLEN-1:0]   quot;
  logic [XLEN-1:0]   rem;

  alu_rsp_t          rsp_q;
  logic              rsp_valid_q;
  logic              rsp_load;

  always_comb begin
    is_sub       = 1'b0;
    is_cmp       = 1'b0;
    is_mul       = 1'b0;
    is_div       = 1'b0;
    sh_kind      = SHIFT_SLL;
    mul_a_signed = 1'b0;
    mul_b_signed = 1'b0;
    div_signed   = 1'b0;
    div_word     = 1'b0;
    case (req_q.op)
      ALU_SUB:           is_sub = 1'b1;
      ALU_SRL, ALU_SRLW: sh_kind = SHIFT_SRL;
      ALU_SRA, ALU_SRAW: sh_kind = SHIFT_SRA;
      ALU_SLT, ALU_SLTU, ALU_BEQ, ALU_BNE,
      ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU: is_cmp = 1'b1;
      ALU_MUL, ALU_MULH, ALU_MULW: begin
        is_mul       = 1'b1;
        mul_a_signed = 1'b1;
        mul_b_signed = 1'b1;
      end
      ALU_MULHSU: begin
        is_mul       = 1'b1;
        mul_a_signed = 1'b1;
      end
      ALU_MULHU:         is_mul = 1'b1;
      ALU_DIV, ALU_REM: begin
        is_div     = 1'b1;
        div_signed = 1'b1;
      end
      ALU_DIVU, ALU_REMU: is_div = 1'b1;
      ALU_DIVW, ALU_REMW: begin
        is_div     = 1'b1;
        div_signed = 1'b1;
        div_word   = 1'b1;
      end
      ALU_DIVUW, ALU_REMUW: begin
        is_div   = 1'b1;
        div_word = 1'b1;
      end
      default: ;
    endcase
  end

  assign sh_word = req_q.op inside {ALU_SLLW, ALU_SRLW, ALU_SRAW};

  alu_addsub_cmp u_alu_addsub_cmp (
    .a_i   (req_q.a),
    .b_i   (req_q.b),
    .sub_i (is_sub | is_cmp),  // compares subtract too
    .sum_o (sum),
    .lt_o  (lt),
    .ltu_o (ltu),
    .eq_o  (eq)
  );

  alu_shift u_alu_shift (
    .a_i     (req_q.a),
    .shamt_i (req_q.b[SHAMT_W-1:0]),
    .kind_i  (sh_kind),
    .word_i  (sh_word),
    .shift_o (shift_res)
  );

  always_comb begin
    case (req_q.op)
      ALU_SLT, ALU_BLT:   cmp_bit = lt;
      ALU_SLTU, ALU_BLTU: cmp_bit = ltu;
      ALU_BEQ:            cmp_bit = eq;
      ALU_BNE:            cmp_bit = ~eq;
      ALU_BGE:            cmp_bit = ~lt;
      ALU_BGEU:           cmp_bit = ~ltu;
      default:            cmp_bit = 1'b0;
    endcase
  end

  always_comb begin
    case (req_q.op)
      ALU_ADD, ALU_SUB: fast_result = sum;
      ALU_AND:          fast_result = req_q.a & req_q.b;
      ALU_OR:           fast_result = req_q.a | req_q.b;
      ALU_XOR:          fast_result = req_q.a ^ req_q.b;
      ALU_SLL, ALU_SRL, ALU_SRA,
      ALU_SLLW, ALU_SRLW, ALU_SRAW: fast_result = shift_res;
      default:          fast_result = {{(XLEN-1){1'b0}}, cmp_bit};  // compares
    endcase
  end

  // start pulses in the cycle after accept
  assign mul_start = act_q & is_mul;
  assign div_start = act_q & is_div;

  alu_mul u_alu_mul (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .start_i    (mul_start),
    .a_signed_i (mul_a_signed),
    .b_signed_i (mul_b_signed),
    .a_i        (req_q.a),
    .b_i        (req_q.b),
    .busy_o     (mul_busy),
    .done_o     (mul_done),
    .prod_o     (prod)
  );

  alu_div u_alu_div (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .start_i  (div_start),
    .signed_i (div_signed),
    .word_i   (div_word),
    .a_i      (req_q.a),
    .b_i      (req_q.b),
    .busy_o   (div_busy),
    .done_o   (div_done),
    .quot_o   (quot),
    .rem_o    (rem)
  );

  always_comb begin
    case (req_q.op)
      ALU_MUL:                         slow_result = prod[XLEN-1:0];
      ALU_MULH, ALU_MULHSU, ALU_MULHU: slow_result = prod[2*XLEN-1:XLEN];
      ALU_MULW: slow_result = {{(XLEN-WLEN){prod[WLEN-1]}}, prod[WLEN-1:0]};
      ALU_REM, ALU_REMU, ALU_REMW, ALU_REMUW: slow_result = rem;
      default:                         slow_result = quot;
    endcase
  end

  // idle and nothing waiting at the output
  assign req_ready_o = ~act_q & ~rsp_valid_q & ~mul_busy & ~div_busy
                     & ~mul_done & ~div_done;
  assign accept      = req_valid_i & req_ready_o;

  assign rsp_load = (act_q & ~is_mul & ~is_div) | mul_done | div_done;

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      act_q       <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      act_q <= accept;
      if (rsp_load) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_ready_i) begin
        rsp_valid_q <= 1'b0;  // response taken
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_load) begin
      rsp_q.result <= (mul_done | div_done) ? slow_result : fast_result;
      rsp_q.cmp    <= cmp_bit;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

//--- hw/alu_div.sv
`default_nettype none

module alu_div (
  input  wire                      clk,
  input  wire                      rst_n_i,
  input  wire                      start_i,
  input  wire                      signed_i,
  input  wire                      word_i,
  input  wire  [alu_pkg::XLEN-1:0] a_i,
  input  wire  [alu_pkg::XLEN-1:0] b_i,
  output logic                     busy_o,
  output logic                     done_o,
  output logic [alu_pkg::XLEN-1:0] quot_o,
  output logic [alu_pkg::XLEN-1:0] rem_o
);

  import alu_pkg::*;

  logic             a_fill;
  logic             b_fill;
  logic [XLEN-1:0]  a_ext;
  logic [XLEN-1:0]  b_ext;
  logic             a_neg;
  logic             b_neg;
  logic [XLEN-1:0]  a_mag;
  logic [XLEN-1:0]  b_mag;
  logic             load;

  logic [XLEN-1:0]  quot_q;  // dividend bits out, quotient bits in
  logic [XLEN-1:0]  rem_q;
  logic [XLEN-1:0]  dvsr_q;
  logic [XLEN-1:0]  dvnd_q;  // extended dividend, kept for the special cases
  logic             quot_neg_q;
  logic             rem_neg_q;
  logic             by_zero_q;
  logic             ovf_q;
  logic             word_q;
  logic [CNT_W-1:0] cnt_q;

  logic [XLEN:0]    shifted;
  logic [XLEN:0]    diff;
  logic [XLEN-1:0]  quot_fix;
  logic [XLEN-1:0]  rem_fix;
  logic [XLEN-1:0]  quot_sel;
  logic [XLEN-1:0]  rem_sel;

  // word forms extend the low half first
  assign a_fill = signed_i & a_i[WLEN-1];
  assign b_fill = signed_i & b_i[WLEN-1];
  assign a_ext  = word_i ? {{(XLEN-WLEN){a_fill}}, a_i[WLEN-1:0]} : a_i;
  assign b_ext  = word_i ? {{(XLEN-WLEN){b_fill}}, b_i[WLEN-1:0]} : b_i;

  assign a_neg = signed_i & a_ext[XLEN-1];
  assign b_neg = signed_i & b_ext[XLEN-1];
  assign a_mag = a_neg ? -a_ext : a_ext;
  assign b_mag = b_neg ? -b_ext : b_ext;

  assign load = start_i & ~busy_o;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      busy_o <= 1'b0;
      done_o <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_o <= 1'b0;
      if (busy_o) begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == CNT_W'(DIV_CYCLES - 1)) begin
          busy_o <= 1'b0;
          done_o <= 1'b1;
        end
      end else if (load) begin
        busy_o <= 1'b1;
        cnt_q  <= '0;
      end
    end
  end

  // restoring step
  assign shifted = {rem_q, quot_q[XLEN-1]};
  assign diff    = shifted - {1'b0, dvsr_q};

  always_ff @(posedge clk) begin
    if (load) begin
      quot_q     <= a_mag;
      rem_q      <= '0;
      dvsr_q     <= b_mag;
      dvnd_q     <= a_ext;
      quot_neg_q <= a_neg ^ b_neg;
      rem_neg_q  <= a_neg;  // remainder follows the dividend
      by_zero_q  <= (b_ext == '0);
      ovf_q      <= signed_i & (a_ext == {1'b1, {(XLEN-1){1'b0}}}) & (b_ext == '1);
      word_q     <= word_i;
    end else if (busy_o) begin
      if (!diff[XLEN]) begin  // divisor fits
        rem_q  <= diff[XLEN-1:0];
        quot_q <= {quot_q[XLEN-2:0], 1'b1};
      end else begin
        rem_q  <= shifted[XLEN-1:0];
        quot_q <= {quot_q[XLEN-2:0], 1'b0};
      end
    end
  end

  assign quot_fix = quot_neg_q ? -quot_q : quot_q;
  assign rem_fix  = rem_neg_q ? -rem_q : rem_q;

  always_comb begin
    if (by_zero_q) begin
      quot_sel = '1;
      rem_sel  = dvnd_q;
    end else if (ovf_q) begin
      quot_sel = dvnd_q;
      rem_sel  = '0;
    end else begin
      quot_sel = quot_fix;
      rem_sel  = rem_fix;
    end
  end

  assign quot_o = word_q ? {{(XLEN-WLEN){quot_sel[WLEN-1]}}, quot_sel[WLEN-1:0]} : quot_sel;
  assign rem_o  = word_q ? {{(XLEN-WLEN){rem_sel[WLEN-1]}}, rem_sel[WLEN-1:0]} : rem_sel;

endmodule

`default_nettype wire

//--- hw/alu_mul.sv
`default_nettype none

module alu_mul (
  input  wire                        clk,
  input  wire                        rst_n_i,
  input  wire                        start_i,
  input  wire                        a_signed_i,
  input  wire                        b_signed_i,
  input  wire  [alu_pkg::XLEN-1:0]   a_i,
  input  wire  [alu_pkg::XLEN-1:0]   b_i,
  output logic                       busy_o,
  output logic                       done_o,
  output logic [2*alu_pkg::XLEN-1:0] prod_o
);

  import alu_pkg::*;

  logic              a_neg;
  logic              b_neg;
  logic [XLEN-1:0]   a_mag;
  logic [XLEN-1:0]   b_mag;
  logic              load;

  logic [2*XLEN-1:0] mcand_q;   // multiplicand, moves up one bit per step
  logic [XLEN-1:0]   mplier_q;  // multiplier, consumed from bit 0
  logic [2*XLEN-1:0] acc_q;
  logic              neg_q;
  logic [CNT_W-1:0]  cnt_q;

  assign a_neg = a_signed_i & a_i[XLEN-1];
  assign b_neg = b_signed_i & b_i[XLEN-1];
  assign a_mag = a_neg ? -a_i : a_i;
  assign b_mag = b_neg ? -b_i : b_i;

  assign load = start_i & ~busy_o;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      busy_o <= 1'b0;
      done_o <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_o <= 1'b0;
      if (busy_o) begin
        cnt_q <= cnt_q + 1'b1;
        // last step, product is final after this edge
        if (cnt_q == CNT_W'(MUL_CYCLES - 1)) begin
          busy_o <= 1'b0;
          done_o <= 1'b1;
        end
      end else if (load) begin
        busy_o <= 1'b1;
        cnt_q  <= '0;
      end
    end
  end

  // shift-add on magnitudes
  always_ff @(posedge clk) begin
    if (load) begin
      mcand_q  <= {{XLEN{1'b0}}, a_mag};
      mplier_q <= b_mag;
      acc_q    <= '0;
      neg_q    <= a_neg ^ b_neg;
    end else if (busy_o) begin
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // sign restored on the full 128-bit product
  assign prod_o = neg_q ? -acc_q : acc_q;

endmodule

`default_nettype wire

//--- hw/alu_shift.sv
`default_nettype none

module alu_shift (
  input  wire  [alu_pkg::XLEN-1:0]    a_i,
  input  wire  [alu_pkg::SHAMT_W-1:0] shamt_i,
  input  wire  [1:0]                  kind_i,
  input  wire                         word_i,
  output logic [alu_pkg::XLEN-1:0]    shift_o
);

  import alu_pkg::*;

  logic [XLEN-1:0]     res64;
  logic [WLEN-1:0]     res32;
  logic [WLEN-1:0]     a_lo;
  logic [WSHAMT_W-1:0] sh_lo;

  // word forms only look at the low half and 5 shift bits
  assign a_lo  = a_i[WLEN-1:0];
  assign sh_lo = shamt_i[WSHAMT_W-1:0];

  always_comb begin
    case (kind_i)
      SHIFT_SRL: begin
        res64 = a_i >> shamt_i;
        res32 = a_lo >> sh_lo;
      end
      SHIFT_SRA: begin
        res64 = $signed(a_i) >>> shamt_i;
        res32 = $signed(a_lo) >>> sh_lo;
      end
      default: begin  // sll
        res64 = a_i << shamt_i;
        res32 = a_lo << sh_lo;
      end
    endcase
  end

  assign shift_o = word_i ? {{(XLEN-WLEN){res32[WLEN-1]}}, res32} : res64;

endmodule

`default_nettype wire

//--- hw/alu_addsub_cmp.sv
`default_nettype none

module alu_addsub_cmp (
  input  wire  [alu_pkg::XLEN-1:0] a_i,
  input  wire  [alu_pkg::XLEN-1:0] b_i,
  input  wire                      sub_i,
  output logic [alu_pkg::XLEN-1:0] sum_o,
  output logic                     lt_o,
  output logic                     ltu_o,
  output logic                     eq_o
);

  import alu_pkg::*;

  logic [XLEN:0] a_ext;
  logic [XLEN:0] b_ext;
  logic [XLEN:0] sum_ext;
  logic          sign;
  logic          ovf;
  logic          carry;

  // one extra sign bit on both sides
  assign a_ext = {a_i[XLEN-1], a_i};
  assign b_ext = {b_i[XLEN-1], b_i} ^ {(XLEN+1){sub_i}};  // invert b for a - b

  assign sum_ext = a_ext + b_ext + {{XLEN{1'b0}}, sub_i};
  assign sum_o   = sum_ext[XLEN-1:0];

  assign sign  = sum_ext[XLEN-1];
  assign ovf   = sum_ext[XLEN] ^ sum_ext[XLEN-1];

  // carry out of the 64-bit add, recovered from the extension bit
  assign carry = sum_ext[XLEN] ^ a_ext[XLEN] ^ b_ext[XLEN];

  assign lt_o  = sign ^ ovf;
  assign ltu_o = sub_i ^ carry;  // borrow on subtract
  assign eq_o  = (sum_ext[XLEN-1:0] == '0);

endmodule

`default_nettype wire

//--- hw/alu_pkg.sv
`default_nettype none

package alu_pkg;

  localparam int unsigned XLEN     = 64;
  localparam int unsigned WLEN     = 32;  // word forms
  localparam int unsigned ALU_OP_W = 5;
  localparam int unsigned SHAMT_W  = $clog2(XLEN);
  localparam int unsigned WSHAMT_W = $clog2(WLEN);

  // iteration counts of the multi-cycle units
  localparam int unsigned MUL_CYCLES = 64;
  localparam int unsigned DIV_CYCLES = 64;
  localparam int unsigned CNT_W      = $clog2(DIV_CYCLES);

  // shifter kind codes
  localparam logic [1:0] SHIFT_SLL = 2'd0;
  localparam logic [1:0] SHIFT_SRL = 2'd1;
  localparam logic [1:0] SHIFT_SRA = 2'd2;

  typedef enum logic [ALU_OP_W-1:0] {
    ALU_ADD    = 5'd0,
    ALU_SUB    = 5'd1,
    ALU_AND    = 5'd2,
    ALU_OR     = 5'd3,
    ALU_XOR    = 5'd4,
    ALU_SLL    = 5'd5,
    ALU_SRL    = 5'd6,
    ALU_SRA    = 5'd7,
    ALU_SLLW   = 5'd8,
    ALU_SRLW   = 5'd9,
    ALU_SRAW   = 5'd10,
    ALU_SLT    = 5'd11,
    ALU_SLTU   = 5'd12,
    ALU_BEQ    = 5'd13,
    ALU_BNE    = 5'd14,
    ALU_BLT    = 5'd15,
    ALU_BGE    = 5'd16,
    ALU_BLTU   = 5'd17,
    ALU_BGEU   = 5'd18,
    ALU_MUL    = 5'd19,
    ALU_MULH   = 5'd20,
    ALU_MULHSU = 5'd21,
    ALU_MULHU  = 5'd22,
    ALU_MULW   = 5'd23,
    ALU_DIV    = 5'd24,
    ALU_DIVU   = 5'd25,
    ALU_REM    = 5'd26,
    ALU_REMU   = 5'd27,
    ALU_DIVW   = 5'd28,
    ALU_DIVUW  = 5'd29,
    ALU_REMW   = 5'd30,
    ALU_REMUW  = 5'd31
  } alu_op_e;

  typedef struct packed {
    alu_op_e         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
  } alu_req_t;

  typedef struct packed {
    logic [XLEN-1:0] result;
    logic            cmp;  // branch / set-less-than outcome
  } alu_rsp_t;

endpackage

`default_nettype wire
